//--- ow_pkg.sv
`default_nettype none

package ow_pkg;

    // The ROM code is shifted out as a flat word and read back as its fields.
    typedef union packed {
        logic [63:0] bits;
        struct packed {
            logic [7:0]  crc;
            logic [47:0] serial;
            logic [7:0]  family;
        } fields;
    } ow_rom_code_u;

    typedef struct packed {
        logic [7:0]   rom_command;
        logic         match_rom;     // Send the ROM code after the ROM command.
        ow_rom_code_u rom_code;
        logic [7:0]   func_cmd;
        logic [15:0]  address;
        logic         is_write;      // High writes data bytes, low reads them.
        logic [5:0]   length;        // Number of data bytes minus one.
    } ow_cmd_t;

    typedef struct packed {
        logic       presence_ok;
        logic [6:0] bytes_done;
    } ow_status_t;

    typedef enum logic [1:0] {
        SLOT_RESET,
        SLOT_WRITE0,
        SLOT_WRITE1,
        SLOT_READ
    } ow_slot_e;

    typedef enum logic [1:0] {
        BYTE_SEND,
        BYTE_RECV
    } ow_byte_op_e;

    // Standard speed counts for a 50 MHz clock.
    localparam logic [15:0] DEF_RESET_LOW       = 16'd24000;  // 480 us.
    localparam logic [15:0] DEF_PRESENCE_SAMPLE = 16'd3500;   // 70 us after release.
    localparam logic [15:0] DEF_RESET_RECOVER   = 16'd24000;
    localparam logic [15:0] DEF_SLOT_LEN        = 16'd3500;
    localparam logic [15:0] DEF_WRITE0_LOW      = 16'd3000;
    localparam logic [15:0] DEF_WRITE1_LOW      = 16'd500;
    localparam logic [15:0] DEF_READ_INIT       = 16'd300;
    localparam logic [15:0] DEF_READ_SAMPLE     = 16'd700;

    localparam logic [3:0] CREDIT_MAX = 4'd8;

endpackage

`default_nettype wire

//--- ow_slot_timer.sv
`timescale 1ns/1ps
`default_nettype none

module ow_slot_timer
    import ow_pkg::*;
#(
    parameter logic [15:0] RESET_LOW       = DEF_RESET_LOW,
    parameter logic [15:0] PRESENCE_SAMPLE = DEF_PRESENCE_SAMPLE,
    parameter logic [15:0] RESET_RECOVER   = DEF_RESET_RECOVER,
    parameter logic [15:0] SLOT_LEN        = DEF_SLOT_LEN,
    parameter logic [15:0] WRITE0_LOW      = DEF_WRITE0_LOW,
    parameter logic [15:0] WRITE1_LOW      = DEF_WRITE1_LOW,
    parameter logic [15:0] READ_INIT       = DEF_READ_INIT,
    parameter logic [15:0] READ_SAMPLE     = DEF_READ_SAMPLE
) (
    input  logic     clk,
    input  logic     reset_flag,
    input  logic     slot_start,
    input  ow_slot_e slot_kind,
    input  logic     rst_start,
    output logic     slot_ready,
    output logic     slot_done,
    output logic     slot_bit,
    input  logic     data_in,
    output logic     data_out
);

    // Down-counter values at which the line is sampled in the released part.
    localparam logic [15:0] READ_PICK  = SLOT_LEN - READ_SAMPLE - 16'd1;
    localparam logic [15:0] RESET_PICK = RESET_RECOVER - PRESENCE_SAMPLE - 16'd1;

    typedef enum logic [1:0] {PH_IDLE, PH_LOW, PH_REL} phase_e;

    phase_e      phase;
    ow_slot_e    kind_q;
    logic [15:0] cnt;
    logic        start_any;
    ow_slot_e    start_kind;
    logic        sample_hit;

    function automatic logic [15:0] low_cycles(ow_slot_e kind);
        case (kind)
            SLOT_RESET:  return RESET_LOW;
            SLOT_WRITE0: return WRITE0_LOW;
            SLOT_WRITE1: return WRITE1_LOW;
            default:     return READ_INIT;
        endcase
    endfunction

    function automatic logic [15:0] rel_cycles(ow_slot_e kind);
        case (kind)
            SLOT_RESET:  return RESET_RECOVER;
            SLOT_WRITE0: return SLOT_LEN - WRITE0_LOW;
            SLOT_WRITE1: return SLOT_LEN - WRITE1_LOW;
            default:     return SLOT_LEN - READ_INIT;
        endcase
    endfunction

    assign slot_ready = (phase == PH_IDLE);
    assign start_any  = slot_ready && (rst_start || slot_start);
    assign start_kind = rst_start ? SLOT_RESET : slot_kind;

    assign sample_hit = (phase == PH_REL) &&
                        (((kind_q == SLOT_READ) && (cnt == READ_PICK)) ||
                         ((kind_q == SLOT_RESET) && (cnt == RESET_PICK)));

    always_ff @(posedge clk) begin
        if (reset_flag) begin
            phase     <= PH_IDLE;
            kind_q    <= SLOT_RESET;
            cnt       <= 16'd0;
            slot_done <= 1'b0;
            data_out  <= 1'b1;
        end else begin
            slot_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start_any) begin
                        kind_q   <= start_kind;
                        cnt      <= low_cycles(start_kind) - 16'd1;
                        data_out <= 1'b0;
                        phase    <= PH_LOW;
                    end
                end
                PH_LOW: begin
                    if (cnt == 16'd0) begin
                        cnt      <= rel_cycles(kind_q) - 16'd1;
                        data_out <= 1'b1;  // Release the line and let the pull-up take it.
                        phase    <= PH_REL;
                    end else begin
                        cnt <= cnt - 16'd1;
                    end
                end
                PH_REL: begin
                    if (cnt == 16'd0) begin
                        slot_done <= 1'b1;
                        phase     <= PH_IDLE;
                    end else begin
                        cnt <= cnt - 16'd1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // A presence pulse is a low line, so the reset slot reports the inverse.
    always_ff @(posedge clk) begin
        if (sample_hit) begin
            slot_bit <= (kind_q == SLOT_RESET) ? !data_in : data_in;
        end
    end

endmodule

`default_nettype wire

//--- ow_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

module ow_byte_engine
    import ow_pkg::*;
(
    input  logic        clk,
    input  logic        reset_flag,
    input  logic        byte_start,
    input  ow_byte_op_e byte_op,
    input  logic [7:0]  byte_tx,
    output logic        byte_done,
    output logic [7:0]  byte_rx,
    output logic        slot_start,
    output ow_slot_e    slot_kind,
    input  logic        slot_ready,
    input  logic        slot_done,
    input  logic        slot_bit
);

    logic [7:0]  shift_q;
    logic [2:0]  bit_cnt;
    ow_byte_op_e op_q;
    logic        busy;
    logic        issued;  // A slot for the current bit is on the bus.
    logic        bit_end;

    assign slot_start = busy && !issued && slot_ready;
    assign slot_kind  = (op_q == BYTE_RECV) ? SLOT_READ :
                        (shift_q[0] ? SLOT_WRITE1 : SLOT_WRITE0);
    assign bit_end    = busy && issued && slot_done;
    assign byte_rx    = shift_q;

    always_ff @(posedge clk) begin
        if (reset_flag) begin
            busy      <= 1'b0;
            issued    <= 1'b0;
            bit_cnt   <= 3'd0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (!busy) begin
                if (byte_start) begin
                    busy    <= 1'b1;
                    issued  <= 1'b0;
                    bit_cnt <= 3'd0;
                end
            end else if (slot_start) begin
                issued <= 1'b1;
            end else if (bit_end) begin
                issued  <= 1'b0;
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    busy      <= 1'b0;
                    byte_done <= 1'b1;
                end
            end
        end
    end

    // Bits leave from bit 0 and arrive at bit 7, so both directions are LSB first.
    always_ff @(posedge clk) begin
        if (byte_start && !busy) begin
            shift_q <= byte_tx;
            op_q    <= byte_op;
        end else if (bit_end) begin
            shift_q <= {slot_bit, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- ow_txn_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ow_txn_sequencer
    import ow_pkg::*;
(
    input  logic        clk,
    input  logic        reset_flag,
    input  ow_cmd_t     cmd,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    output logic        done,
    output ow_status_t  status,
    output logic        byte_start,
    output ow_byte_op_e byte_op,
    output logic [7:0]  byte_tx,
    input  logic        byte_done,
    input  logic [7:0]  byte_rx,
    output logic        rst_start,
    input  logic        rst_done,
    input  logic        rst_presence,
    output logic        wr_req,
    output logic [5:0]  wr_index,
    input  logic        wr_valid,
    input  logic [7:0]  wr_data,
    input  logic        hold_free,
    output logic        hold_load,
    output logic [7:0]  hold_byte
);

    typedef enum logic [3:0] {
        ST_IDLE, ST_RESET, ST_RESET_WAIT, ST_ROM, ST_CODE, ST_FUNC,
        ST_ADDR_LO, ST_ADDR_HI, ST_WR_FETCH, ST_WR_WAIT, ST_DATA, ST_FINISH
    } state_e;

    state_e       state;
    ow_cmd_t      cmd_q;
    ow_rom_code_u code_q;
    logic [7:0]   wr_byte_q;
    logic [6:0]   byte_cnt;
    logic         pres_q;
    logic         byte_busy;

    assign cmd_ready = (state == ST_IDLE);
    assign rst_start = (state == ST_RESET);
    assign wr_req    = (state == ST_WR_FETCH);
    assign wr_index  = byte_cnt[5:0];
    assign byte_op   = (state == ST_DATA && !cmd_q.is_write) ? BYTE_RECV : BYTE_SEND;
    assign hold_load = (state == ST_DATA) && !cmd_q.is_write && byte_done;
    assign hold_byte = byte_rx;
    assign status    = '{presence_ok: pres_q, bytes_done: byte_cnt};
    assign done      = (state == ST_FINISH) && (!pres_q || cmd_q.is_write || hold_free);

    always_comb begin
        byte_start = 1'b0;
        byte_tx    = 8'h00;
        case (state)
            ST_ROM:     byte_tx = cmd_q.rom_command;
            ST_CODE:    byte_tx = code_q.fields.family;  // Next code byte after shifting.
            ST_FUNC:    byte_tx = cmd_q.func_cmd;
            ST_ADDR_LO: byte_tx = cmd_q.address[7:0];
            ST_ADDR_HI: byte_tx = cmd_q.address[15:8];
            ST_DATA:    byte_tx = wr_byte_q;
            default:    byte_tx = 8'h00;
        endcase
        case (state)
            ST_ROM, ST_CODE, ST_FUNC, ST_ADDR_LO, ST_ADDR_HI: byte_start = !byte_busy;
            ST_DATA: byte_start = !byte_busy && (cmd_q.is_write || hold_free);
            default: byte_start = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_flag) begin
            state     <= ST_IDLE;
            byte_busy <= 1'b0;
            byte_cnt  <= 7'd0;
            pres_q    <= 1'b0;
        end else begin
            if (byte_start) begin
                byte_busy <= 1'b1;
            end else if (byte_done) begin
                byte_busy <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        byte_cnt <= 7'd0;
                        pres_q   <= 1'b0;
                        state    <= ST_RESET;
                    end
                end
                ST_RESET: state <= ST_RESET_WAIT;
                ST_RESET_WAIT: begin
                    if (rst_done) begin
                        pres_q <= rst_presence;
                        state  <= rst_presence ? ST_ROM : ST_FINISH;
                    end
                end
                ST_ROM: begin
                    if (byte_done) begin
                        state <= cmd_q.match_rom ? ST_CODE : ST_FUNC;
                    end
                end
                ST_CODE: begin
                    if (byte_done) begin
                        byte_cnt <= (byte_cnt == 7'd7) ? 7'd0 : byte_cnt + 7'd1;
                        if (byte_cnt == 7'd7) begin
                            state <= ST_FUNC;
                        end
                    end
                end
                ST_FUNC:    if (byte_done) state <= ST_ADDR_LO;
                ST_ADDR_LO: if (byte_done) state <= ST_ADDR_HI;
                ST_ADDR_HI: begin
                    if (byte_done) begin
                        state <= cmd_q.is_write ? ST_WR_FETCH : ST_DATA;
                    end
                end
                ST_WR_FETCH: state <= ST_WR_WAIT;
                ST_WR_WAIT:  if (wr_valid) state <= ST_DATA;
                ST_DATA: begin
                    if (byte_done) begin
                        byte_cnt <= byte_cnt + 7'd1;
                        if (byte_cnt[5:0] == cmd_q.length) begin
                            state <= ST_FINISH;
                        end else if (cmd_q.is_write) begin
                            state <= ST_WR_FETCH;
                        end
                    end
                end
                ST_FINISH: if (done) state <= ST_IDLE;  // A read waits for its last byte to leave.
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q  <= cmd;
            code_q <= cmd.rom_code;
        end else if (state == ST_CODE && byte_done) begin
            code_q.bits <= code_q.bits >> 8;
        end
        if (state == ST_WR_WAIT && wr_valid) begin
            wr_byte_q <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- ow_read_credit.sv
`timescale 1ns/1ps
`default_nettype none

module ow_read_credit
    import ow_pkg::*;
#(
    parameter logic [3:0] CREDIT_MAX = ow_pkg::CREDIT_MAX
) (
    input  logic       clk,
    input  logic       reset_flag,
    input  logic       hold_load,
    input  logic [7:0] hold_byte,
    output logic       hold_free,
    input  logic       credit_return,
    output logic       rd_valid,
    output logic [7:0] rd_data
);

    logic [3:0] credits;
    logic [7:0] hold_q;
    logic       held;
    logic       grant;

    assign hold_free = !held;
    assign rd_valid  = held && (credits != 4'd0);
    assign rd_data   = hold_q;
    // A full counter still takes a return when a credit is spent in the same cycle.
    assign grant     = credit_return && ((credits != CREDIT_MAX) || rd_valid);

    always_ff @(posedge clk) begin
        if (reset_flag) begin
            credits <= 4'd0;
            held    <= 1'b0;
        end else begin
            case ({grant, rd_valid})
                2'b10:   credits <= credits + 4'd1;
                2'b01:   credits <= credits - 4'd1;
                default: credits <= credits;
            endcase
            if (hold_load) begin
                held <= 1'b1;
            end else if (rd_valid) begin
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hold_load) begin
            hold_q <= hold_byte;
        end
    end

endmodule

`default_nettype wire

//--- ow_master.sv
`timescale 1ns/1ps
`default_nettype none

module ow_master
    import ow_pkg::*;
#(
    parameter logic [15:0] RESET_LOW       = DEF_RESET_LOW,
    parameter logic [15:0] PRESENCE_SAMPLE = DEF_PRESENCE_SAMPLE,
    parameter logic [15:0] RESET_RECOVER   = DEF_RESET_RECOVER,
    parameter logic [15:0] SLOT_LEN        = DEF_SLOT_LEN,
    parameter logic [15:0] WRITE0_LOW      = DEF_WRITE0_LOW,
    parameter logic [15:0] WRITE1_LOW      = DEF_WRITE1_LOW,
    parameter logic [15:0] READ_INIT       = DEF_READ_INIT,
    parameter logic [15:0] READ_SAMPLE     = DEF_READ_SAMPLE,
    parameter logic [3:0]  CREDIT_MAX      = ow_pkg::CREDIT_MAX
) (
    input  logic       clk,
    input  logic       reset_flag,
    input  ow_cmd_t    cmd,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    output logic       done,
    output ow_status_t status,
    output logic       wr_req,
    output logic [5:0] wr_index,
    input  logic       wr_valid,
    input  logic [7:0] wr_data,
    output logic       rd_valid,
    output logic [7:0] rd_data,
    input  logic       credit_return,
    input  logic       data_in,
    output logic       data_out
);

    logic        byte_start;
    ow_byte_op_e byte_op;
    logic [7:0]  byte_tx;
    logic        byte_done;
    logic [7:0]  byte_rx;
    logic        slot_start;
    ow_slot_e    slot_kind;
    logic        slot_ready;
    logic        slot_done;
    logic        slot_bit;
    logic        rst_start;
    logic        hold_free;
    logic        hold_load;
    logic [7:0]  hold_byte;

    ow_txn_sequencer u_sequencer (
        .clk, .reset_flag, .cmd, .cmd_valid, .cmd_ready, .done, .status,
        .byte_start, .byte_op, .byte_tx, .byte_done, .byte_rx,
        .rst_start, .rst_done(slot_done), .rst_presence(slot_bit),
        .wr_req, .wr_index, .wr_valid, .wr_data,
        .hold_free, .hold_load, .hold_byte
    );

    ow_byte_engine u_byte_engine (
        .clk, .reset_flag, .byte_start, .byte_op, .byte_tx, .byte_done, .byte_rx,
        .slot_start, .slot_kind, .slot_ready, .slot_done, .slot_bit
    );

    // The reset request only comes while the byte engine is idle.
    ow_slot_timer #(
        .RESET_LOW(RESET_LOW), .PRESENCE_SAMPLE(PRESENCE_SAMPLE),
        .RESET_RECOVER(RESET_RECOVER), .SLOT_LEN(SLOT_LEN),
        .WRITE0_LOW(WRITE0_LOW), .WRITE1_LOW(WRITE1_LOW),
        .READ_INIT(READ_INIT), .READ_SAMPLE(READ_SAMPLE)
    ) u_slot_timer (
        .clk, .reset_flag, .slot_start, .slot_kind, .rst_start,
        .slot_ready, .slot_done, .slot_bit, .data_in, .data_out
    );

    ow_read_credit #(
        .CREDIT_MAX(CREDIT_MAX)
    ) u_read_credit (
        .clk, .reset_flag, .hold_load, .hold_byte, .hold_free,
        .credit_return, .rd_valid, .rd_data
    );

endmodule

`default_nettype wire

//--- tb_ow_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ow_master
    import ow_pkg::*;
();

    localparam int          CLK_PERIOD  = 4;
    localparam logic [15:0] T_RESET_LOW = 16'd200;
    localparam logic [15:0] T_PRESENCE  = 16'd30;
    localparam logic [15:0] T_RECOVER   = 16'd200;
    localparam logic [15:0] T_SLOT      = 16'd40;
    localparam logic [15:0] T_W0        = 16'd30;
    localparam logic [15:0] T_W1        = 16'd4;
    localparam logic [15:0] T_RINIT     = 16'd3;
    localparam logic [15:0] T_RSAMPLE   = 16'd10;
    localparam int BYTE_WC    = 8 * (T_SLOT + 4) + 8;
    localparam int RESET_WC   = T_RESET_LOW + T_RECOVER + 8;
    localparam int BP_WAIT    = 12 * T_SLOT;   // Longer than one read byte on the bus.
    localparam int RUN_CYCLES = 200 + 5 * RESET_WC + 36 * BYTE_WC + 5 * BP_WAIT;

    logic        clk = 1'b0;
    logic        reset_flag;
    ow_cmd_t     cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        done;
    ow_status_t  status;
    logic        wr_req;
    logic [5:0]  wr_index;
    logic        wr_valid;
    logic [7:0]  wr_data;
    logic        rd_valid;
    logic [7:0]  rd_data;
    logic        credit_return;
    logic        data_out;
    logic        slave_drive = 1'b1;
    logic        bus_line;

    logic [15:0] lfsr_state = 16'd50570;
    logic [7:0]  wr_mem [64];
    logic [7:0]  exp_bytes [$];
    logic [7:0]  sent_bytes [$];
    logic [7:0]  rd_got [$];
    logic [5:0]  wr_seen [$];
    logic        send_bits [$];
    logic        rx_bits [$];
    ow_status_t  last_status;
    int          done_cnt;
    int          low_pulses;
    int          resets_seen;
    int          bit_count;
    int          read_from = 1000;   // First bus bit of the read slots.
    bit          presence_on;
    int          low_len;
    int          hold_cnt;
    int          pres_delay;
    int          wr_wait;
    logic [5:0]  wr_pend;
    logic        prev_out;

    assign bus_line = data_out & slave_drive;   // Open-drain line with a pull-up.

    ow_master #(
        .RESET_LOW(T_RESET_LOW), .PRESENCE_SAMPLE(T_PRESENCE), .RESET_RECOVER(T_RECOVER),
        .SLOT_LEN(T_SLOT), .WRITE0_LOW(T_W0), .WRITE1_LOW(T_W1),
        .READ_INIT(T_RINIT), .READ_SAMPLE(T_RSAMPLE), .CREDIT_MAX(4'd8)
    ) u_ow_master (
        .clk, .reset_flag, .cmd, .cmd_valid, .cmd_ready, .done, .status,
        .wr_req, .wr_index, .wr_valid, .wr_data, .rd_valid, .rd_data, .credit_return,
        .data_in(bus_line), .data_out
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished.");
        abort_run();
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR t=%0t %s: expected %0h, got %0h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic lfsr_next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr_next_bit();
        end
        return b;
    endfunction

    // Slave model. Pulses are timed on data_out so the slave's own pull-down never confuses it.
    always @(negedge clk) begin
        if (reset_flag) begin
            slave_drive = 1'b1;
            prev_out    = 1'b1;
            low_len     = 0;
            hold_cnt    = 0;
            pres_delay  = 0;
        end else begin
            if (hold_cnt > 0) begin
                hold_cnt--;
                if (hold_cnt == 0) begin
                    slave_drive = 1'b1;
                end
            end
            if (pres_delay > 0) begin
                pres_delay--;
                if (pres_delay == 0) begin
                    slave_drive = 1'b0;
                    hold_cnt    = T_PRESENCE + 10;
                end
            end
            if (!data_out) begin
                if (prev_out) begin
                    low_pulses++;
                    if (bit_count >= read_from && send_bits.size() > 0) begin
                        if (send_bits.pop_front() == 1'b0) begin
                            slave_drive = 1'b0;   // Hold past the master's sample point.
                            hold_cnt    = T_RSAMPLE + 4;
                        end
                    end
                end
                low_len++;
            end else if (!prev_out) begin
                if (low_len >= T_RESET_LOW / 2) begin
                    resets_seen++;
                    bit_count = 0;
                    if (presence_on) begin
                        pres_delay = 5;
                    end
                end else begin
                    rx_bits.push_back(low_len < (T_W0 + T_W1) / 2);   // Read slots give ones.
                    bit_count++;
                end
                low_len = 0;
            end
            prev_out = data_out;
        end
    end

    // Byte source answers each request a few cycles later.
    always @(negedge clk) begin
        wr_valid = 1'b0;
        if (wr_wait > 0) begin
            wr_wait--;
            if (wr_wait == 0) begin
                wr_valid = 1'b1;
                wr_data  = wr_mem[wr_pend];
            end
        end
        if (wr_req) begin
            wr_pend = wr_index;
            wr_seen.push_back(wr_index);
            wr_wait = 3;
        end
    end

    always @(negedge clk) begin
        if (!reset_flag && rd_valid) begin
            rd_got.push_back(rd_data);
        end
        if (!reset_flag && done) begin
            done_cnt++;
            last_status = status;
        end
    end

    function automatic ow_cmd_t make_cmd(logic match, logic is_write, logic [5:0] length);
        ow_cmd_t c;
        c.rom_command            = match ? 8'h55 : 8'hCC;
        c.match_rom              = match;
        c.rom_code.fields.family = 8'h2D;
        c.rom_code.fields.serial = {random_byte(), random_byte(), random_byte(),
                                    random_byte(), random_byte(), random_byte()};
        c.rom_code.fields.crc    = random_byte();
        c.func_cmd               = is_write ? 8'h0F : 8'hF0;
        c.address                = {random_byte(), random_byte()};
        c.is_write               = is_write;
        c.length                 = length;
        return c;
    endfunction

    task automatic expect_header(ow_cmd_t c);
        exp_bytes.delete();
        exp_bytes.push_back(c.rom_command);
        if (c.match_rom) begin
            exp_bytes.push_back(c.rom_code.fields.family);
            for (int i = 0; i < 6; i++) begin
                exp_bytes.push_back(c.rom_code.fields.serial[8 * i +: 8]);
            end
            exp_bytes.push_back(c.rom_code.fields.crc);
        end
        exp_bytes.push_back(c.func_cmd);
        exp_bytes.push_back(c.address[7:0]);
        exp_bytes.push_back(c.address[15:8]);
    endtask

    task automatic clear_slave();
        rx_bits.delete();
        wr_seen.delete();
        rd_got.delete();
        send_bits.delete();
        bit_count   = 0;
        read_from   = 1000;
        presence_on = 1'b1;
    endtask

    task automatic run_cmd(ow_cmd_t c);
        check_value("cmd_ready", 1, cmd_ready);
        cmd       = c;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        check_value("cmd_ready", 0, cmd_ready);
    endtask

    task automatic wait_done(int limit);
        int start;
        int waited;
        start  = done_cnt;
        waited = 0;
        while (done_cnt == start) begin
            @(negedge clk);
            waited++;
            if (waited > limit) begin
                $display("Timed out after %0d cycles waiting for done.", limit);
                abort_run();
            end
        end
    endtask

    task automatic wait_bits(int n);
        int waited;
        waited = 0;
        while (bit_count < n) begin
            @(negedge clk);
            waited++;
            if (waited > RESET_WC + 6 * BYTE_WC) begin
                $display("Timed out waiting for %0d bus slots.", n);
                abort_run();
            end
        end
    endtask

    task automatic check_decoded(int n, int total);
        logic [7:0] b;
        check_value("decoded bits", 8 * total, rx_bits.size());
        for (int i = 0; i < n; i++) begin
            for (int k = 0; k < 8; k++) begin
                b[k] = rx_bits[8 * i + k];
            end
            check_value($sformatf("bus byte %0d", i), exp_bytes[i], b);
        end
    endtask

    task automatic prepare_read(input logic [5:0] length, output ow_cmd_t c);
        clear_slave();
        c = make_cmd(1'b0, 1'b0, length);
        expect_header(c);
        sent_bytes.delete();
        for (int i = 0; i <= length; i++) begin
            sent_bytes.push_back(random_byte());
            for (int k = 0; k < 8; k++) begin
                send_bits.push_back(sent_bytes[i][k]);
            end
        end
        read_from = 32;   // ROM, function and two address bytes come first.
    endtask

    task automatic check_read_result(ow_cmd_t c);
        check_value("presence_ok", 1, last_status.presence_ok);
        check_value("bytes_done", c.length + 1, last_status.bytes_done);
        check_value("read byte count", c.length + 1, rd_got.size());
        for (int i = 0; i <= c.length; i++) begin
            check_value($sformatf("rd_data %0d", i), sent_bytes[i], rd_got[i]);
        end
        check_decoded(4, 4 + c.length + 1);
    endtask

    task automatic test_after_reset();
        check_value("data_out", 1, data_out);
        check_value("cmd_ready", 1, cmd_ready);
        check_value("done", 0, done);
        check_value("rd_valid", 0, rd_valid);
        check_value("wr_req", 0, wr_req);
        repeat (50) @(negedge clk);
        check_value("idle low pulses", 0, low_pulses);
        check_value("data_out", 1, data_out);
    endtask

    task automatic test_no_presence();
        ow_cmd_t c;
        int      pulses;
        clear_slave();
        presence_on = 1'b0;
        pulses      = low_pulses;
        c = make_cmd(1'b0, 1'b1, 6'd0);
        run_cmd(c);
        wait_done(2 * RESET_WC);
        check_value("presence_ok", 0, last_status.presence_ok);
        check_value("bytes_done", 0, last_status.bytes_done);
        repeat (100) @(negedge clk);
        check_value("low pulses", pulses + 1, low_pulses);
        check_value("decoded bits", 0, rx_bits.size());
    endtask

    task automatic test_match_write();
        ow_cmd_t c;
        int      resets;
        clear_slave();
        resets = resets_seen;
        c = make_cmd(1'b1, 1'b1, 6'd5);
        expect_header(c);
        for (int i = 0; i < 64; i++) begin
            wr_mem[i] = random_byte();
        end
        for (int i = 0; i <= c.length; i++) begin
            exp_bytes.push_back(wr_mem[i]);
        end
        run_cmd(c);
        wait_done(RESET_WC + 20 * BYTE_WC);
        check_value("presence_ok", 1, last_status.presence_ok);
        check_value("bytes_done", c.length + 1, last_status.bytes_done);
        check_value("reset pulses", resets + 1, resets_seen);
        check_value("wr_req count", c.length + 1, wr_seen.size());
        for (int i = 0; i <= c.length; i++) begin
            check_value("wr_index", i, wr_seen[i]);
        end
        check_decoded(exp_bytes.size(), exp_bytes.size());
    endtask

    task automatic test_credit_backpressure();
        ow_cmd_t c;
        int      dones;
        prepare_read(6'd3, c);
        dones = done_cnt;
        run_cmd(c);
        wait_bits(40);
        repeat (BP_WAIT) @(negedge clk);
        check_value("bytes before credit", 0, rd_got.size());
        for (int k = 1; k <= 4; k++) begin
            check_value("done before last byte", dones, done_cnt);
            credit_return = 1'b1;
            @(negedge clk);
            credit_return = 1'b0;
            if (k == 4) begin
                wait_done(2 * BYTE_WC);
            end else begin
                repeat (BP_WAIT) @(negedge clk);
            end
            check_value("bytes after credits", k, rd_got.size());
        end
        check_read_result(c);
    endtask

    task automatic test_free_read();
        ow_cmd_t c;
        prepare_read(6'd5, c);
        credit_return = 1'b1;
        run_cmd(c);
        wait_done(RESET_WC + 20 * BYTE_WC);
        credit_return = 1'b0;
        check_read_result(c);
    endtask

    initial begin
        reset_flag    = 1'b1;
        cmd           = '0;
        cmd_valid     = 1'b0;
        wr_valid      = 1'b0;
        wr_data       = 8'h00;
        credit_return = 1'b0;
        repeat (10) @(negedge clk);
        reset_flag = 1'b0;
        test_after_reset();
        test_no_presence();
        test_match_write();
        test_credit_backpressure();   // Runs before any credit has been returned.
        test_free_read();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- ow_master.f
ow_pkg.sv
ow_slot_timer.sv
ow_byte_engine.sv
ow_txn_sequencer.sv
ow_read_credit.sv
ow_master.sv
tb_ow_master.sv
